// File: design/la_pkg.sv
package la_pkg;

    // ==============================
    // Sizes and rates
    // ==============================
    localparam int SAMPLE_DIV = 25;              // Clocks per sample strobe
    localparam int NUM_CH     = 8;               // Probe channels
    localparam int DISP_BYTES = 38;              // Display bytes per channel
    localparam int DISP_BITS  = DISP_BYTES * 8;  // 304 display columns
    localparam int MEM_AW     = 11;              // 2 KiB on-chip buffer

    typedef logic [NUM_CH-1:0] sample_t;         // Bit c is channel c
    typedef logic [MEM_AW-1:0] mem_addr_t;

    localparam mem_addr_t RAW_BASE  = 11'd0;     // Raw capture region
    localparam mem_addr_t DISP_BASE = 11'd1536;  // Packed display region

    // ==============================
    // Host register map
    // ==============================
    localparam logic [3:0] REG_CTRL   = 4'd0;    // W: arm / regen / read
    localparam logic [3:0] REG_CHAN   = 4'd1;
    localparam logic [3:0] REG_BYTE   = 4'd2;
    localparam logic [3:0] REG_TRIG   = 4'd3;    // [2:0] channel, [3] falling
    localparam logic [3:0] REG_WINDOW = 4'd4;
    localparam logic [3:0] REG_DEBUG  = 4'd5;
    localparam logic [3:0] REG_STATUS = 4'd6;
    localparam logic [3:0] REG_DATA   = 4'd7;

    typedef struct packed {
        logic      en;
        logic      write;
        mem_addr_t addr;
        sample_t   wdata;
    } mem_req_t;

    typedef enum logic [2:0] {IDLE, CAPTURE, CAPTURED, REGEN, READY, READ} phase_t;

    typedef struct packed {
        logic [2:0] channel;
        logic       mode;                        // 0 rising, 1 falling
    } trig_cfg_t;

    typedef struct packed {
        trig_cfg_t  trig;
        logic [1:0] window;                      // Decimation is window + 1
        logic       debug_en;
        logic [2:0] channel;                     // Display readback channel
        logic [5:0] byte_addr;                   // Display readback byte
    } cfg_t;

    typedef struct packed {
        logic arm;
        logic regen;
        logic read;
    } cmd_t;

    typedef struct packed {
        logic busy;
        logic armed;
        logic captured;
        logic ready;
    } status_t;

    typedef struct packed {
        logic       sel;
        logic       write;
        logic [3:0] addr;
        logic [7:0] wdata;
    } bus_req_t;

    // Display byte address, base + ch * 38 + byte
    function automatic mem_addr_t disp_addr(input logic [2:0] ch, input logic [5:0] byte_off);
        return DISP_BASE + mem_addr_t'(ch) * mem_addr_t'(DISP_BYTES) + mem_addr_t'(byte_off);
    endfunction

endpackage

// File: design/probe_front.sv
`timescale 1ns/100ps

module probe_front (
    input  logic            clk,
    input  logic            cmd_reset,
    input  la_pkg::sample_t probe,
    input  logic            debug_en,
    output la_pkg::sample_t sample,
    output logic            strobe
);

    logic [$clog2(la_pkg::SAMPLE_DIV)-1:0] div_cnt;
    la_pkg::sample_t sync1;
    la_pkg::sample_t sync2;
    logic [7:0]      dbg_cnt;                    // Steps once per sample
    la_pkg::sample_t dbg_pat;

    assign strobe = (div_cnt == ($clog2(la_pkg::SAMPLE_DIV))'(la_pkg::SAMPLE_DIV - 1));

    always_ff @(posedge clk) begin
        if (cmd_reset) begin
            div_cnt <= '0;
            dbg_cnt <= '0;
        end else begin
            div_cnt <= strobe ? '0 : div_cnt + 1'b1;
            if (strobe)
                dbg_cnt <= dbg_cnt + 1'b1;
        end
    end

    // Two-flop synchronizer, probes are asynchronous
    always_ff @(posedge clk) begin
        sync1 <= probe;
        sync2 <= sync1;
    end

    // Bit-reversed counter, channel 7 toggles fastest
    always_comb begin
        for (int c = 0; c < la_pkg::NUM_CH; c++)
            dbg_pat[c] = dbg_cnt[la_pkg::NUM_CH - 1 - c];
    end

    assign sample = debug_en ? dbg_pat : sync2;

endmodule

// File: design/capture_engine.sv
`timescale 1ns/100ps

module capture_engine (
    input  logic              clk,
    input  logic              cmd_reset,
    input  logic              arm,
    input  la_pkg::sample_t   sample,
    input  logic              strobe,
    input  la_pkg::trig_cfg_t trig,
    input  logic [1:0]        window,
    output logic              armed,
    output logic              captured,
    output la_pkg::mem_req_t  mem_req
);

    la_pkg::sample_t   prev;                     // Sample from last strobe
    la_pkg::mem_addr_t count;                    // Samples written so far
    la_pkg::mem_addr_t cap_len;
    logic              capturing;
    logic              edge_hit;
    logic              wr_en;

    // Length scales with decimation so regen always finds 304 columns
    assign cap_len = la_pkg::mem_addr_t'(la_pkg::DISP_BITS * (int'(window) + 1));

    always_comb begin
        if (trig.mode)
            edge_hit = prev[trig.channel] && !sample[trig.channel];   // Falling
        else
            edge_hit = !prev[trig.channel] && sample[trig.channel];   // Rising
    end

    // Trigger sample itself lands at RAW_BASE
    assign wr_en = strobe && ((armed && edge_hit) || capturing);

    always_ff @(posedge clk) begin
        if (strobe)
            prev <= sample;
    end

    // ==============================
    // Arm / trigger / fill
    // ==============================
    always_ff @(posedge clk) begin
        if (cmd_reset) begin
            armed     <= 1'b0;
            captured  <= 1'b0;
            capturing <= 1'b0;
            count     <= '0;
        end else if (arm) begin
            armed     <= 1'b1;
            captured  <= 1'b0;
            capturing <= 1'b0;
            count     <= '0;
        end else if (wr_en) begin
            armed     <= 1'b0;
            capturing <= 1'b1;
            count     <= count + 1'b1;
            if (count == cap_len - 1'b1) begin   // Last sample of the window
                capturing <= 1'b0;
                captured  <= 1'b1;
            end
        end
    end

    always_comb begin
        mem_req       = '0;
        mem_req.en    = wr_en;
        mem_req.write = 1'b1;
        mem_req.addr  = la_pkg::RAW_BASE + count;
        mem_req.wdata = sample;
    end

endmodule

// File: design/regen_engine.sv
`timescale 1ns/100ps

module regen_engine (
    input  logic             clk,
    input  logic             cmd_reset,
    input  logic             start,
    input  logic [1:0]       window,
    output la_pkg::mem_req_t mem_req,
    input  la_pkg::sample_t  mem_rdata,
    output logic             done
);

    logic              rd_phase;                 // Fetching 8 raw samples
    logic              wr_phase;                 // Draining 8 channel bytes
    logic              rd_valid;                 // Read data due this cycle
    logic [3:0]        rd_cnt;                   // Reads issued for this byte
    logic [2:0]        ret_cnt;                  // Samples returned
    logic [2:0]        wr_ch;
    logic [5:0]        byte_idx;
    la_pkg::mem_addr_t rd_addr;
    la_pkg::mem_addr_t factor;
    la_pkg::sample_t   chan_byte [la_pkg::NUM_CH];
    logic              issue;
    logic              last_byte;

    assign factor    = la_pkg::mem_addr_t'(window) + 1'b1;
    assign issue     = rd_phase && !rd_cnt[3];   // Up to 8 reads back to back
    assign last_byte = (byte_idx == 6'(la_pkg::DISP_BYTES - 1));
    assign done      = wr_phase && (wr_ch == 3'(la_pkg::NUM_CH - 1)) && last_byte;

    // ==============================
    // Sequencing
    // ==============================
    always_ff @(posedge clk) begin
        if (cmd_reset) begin
            rd_phase <= 1'b0;
            wr_phase <= 1'b0;
            rd_valid <= 1'b0;
            rd_cnt   <= '0;
            ret_cnt  <= '0;
            wr_ch    <= '0;
            byte_idx <= '0;
            rd_addr  <= la_pkg::RAW_BASE;
        end else begin
            rd_valid <= issue;
            if (start) begin
                rd_phase <= 1'b1;
                wr_phase <= 1'b0;
                rd_cnt   <= '0;
                ret_cnt  <= '0;
                wr_ch    <= '0;
                byte_idx <= '0;
                rd_addr  <= la_pkg::RAW_BASE;
            end else begin
                if (issue) begin
                    rd_addr <= rd_addr + factor;       // Keeps running into next byte
                    rd_cnt  <= rd_cnt + 1'b1;
                end
                if (rd_valid) begin
                    ret_cnt <= ret_cnt + 1'b1;
                    if (ret_cnt == 3'd7) begin         // Eighth sample is back
                        rd_phase <= 1'b0;
                        wr_phase <= 1'b1;
                    end
                end
                if (wr_phase) begin
                    wr_ch <= wr_ch + 1'b1;
                    if (wr_ch == 3'(la_pkg::NUM_CH - 1)) begin
                        wr_phase <= 1'b0;
                        rd_phase <= !last_byte;
                        rd_cnt   <= '0;
                        byte_idx <= byte_idx + 1'b1;
                    end
                end
            end
        end
    end

    // First sample ends up in the MSB
    always_ff @(posedge clk) begin
        if (rd_valid) begin
            for (int c = 0; c < la_pkg::NUM_CH; c++)
                chan_byte[c] <= {chan_byte[c][la_pkg::NUM_CH-2:0], mem_rdata[c]};
        end
    end

    always_comb begin
        mem_req = '0;
        if (issue) begin
            mem_req.en   = 1'b1;
            mem_req.addr = rd_addr;
        end else if (wr_phase) begin
            mem_req.en    = 1'b1;
            mem_req.write = 1'b1;
            mem_req.addr  = la_pkg::disp_addr(wr_ch, byte_idx);
            mem_req.wdata = chan_byte[wr_ch];
        end
    end

endmodule

// File: design/sample_ram.sv
`timescale 1ns/100ps

module sample_ram (
    input  logic             clk,
    input  la_pkg::mem_req_t mem_req,
    output la_pkg::sample_t  rdata
);

    // Raw samples low, display buffer from DISP_BASE up
    la_pkg::sample_t mem [2**la_pkg::MEM_AW];

    always_ff @(posedge clk) begin
        if (mem_req.en) begin
            if (mem_req.write)
                mem[mem_req.addr] <= mem_req.wdata;
            rdata <= mem[mem_req.addr];          // Data valid next cycle
        end
    end

endmodule

// File: design/bus_regs.sv
`timescale 1ns/100ps

module bus_regs (
    input  logic              clk,
    input  logic              cmd_reset,
    input  la_pkg::bus_req_t  bus,
    output logic [7:0]        rdata,
    output la_pkg::cfg_t      cfg,
    output la_pkg::cmd_t      cmd,
    input  la_pkg::status_t   status,
    input  la_pkg::sample_t   read_data
);

    logic       wr;
    logic       rd;
    logic [7:0] rd_mux;

    assign wr = bus.sel && bus.write;
    assign rd = bus.sel && !bus.write;

    always_comb begin
        case (bus.addr)
            la_pkg::REG_CHAN:   rd_mux = {5'd0, cfg.channel};
            la_pkg::REG_BYTE:   rd_mux = {2'd0, cfg.byte_addr};
            la_pkg::REG_TRIG:   rd_mux = {4'd0, cfg.trig.mode, cfg.trig.channel};
            la_pkg::REG_WINDOW: rd_mux = {6'd0, cfg.window};
            la_pkg::REG_DEBUG:  rd_mux = {7'd0, cfg.debug_en};
            la_pkg::REG_STATUS: rd_mux = {4'd0, status.ready, status.captured,
                                          status.armed, status.busy};
            la_pkg::REG_DATA:   rd_mux = read_data;
            default:            rd_mux = 8'd0;   // CTRL is write-only
        endcase
    end

    always_ff @(posedge clk) begin
        if (cmd_reset) begin
            cfg   <= '0;
            cmd   <= '0;
            rdata <= '0;
        end else begin
            cmd <= '0;                           // Commands last one cycle
            if (wr) begin
                case (bus.addr)
                    la_pkg::REG_CTRL:   cmd <= '{arm: bus.wdata[0], regen: bus.wdata[1],
                                                 read: bus.wdata[2]};
                    la_pkg::REG_CHAN:   cfg.channel   <= bus.wdata[2:0];
                    la_pkg::REG_BYTE:   cfg.byte_addr <= bus.wdata[5:0];
                    la_pkg::REG_TRIG:   cfg.trig      <= '{channel: bus.wdata[2:0],
                                                           mode: bus.wdata[3]};
                    la_pkg::REG_WINDOW: cfg.window    <= bus.wdata[1:0];
                    la_pkg::REG_DEBUG:  cfg.debug_en  <= bus.wdata[0];
                    default: ;
                endcase
            end
            if (rd)
                rdata <= rd_mux;                 // Held until next read
        end
    end

endmodule

// File: design/phase_ctrl.sv
`timescale 1ns/100ps

module phase_ctrl (
    input  logic             clk,
    input  logic             cmd_reset,
    input  la_pkg::cmd_t     cmd,
    input  la_pkg::cfg_t     cfg,
    input  logic             captured,
    input  logic             armed,
    input  logic             regen_done,
    input  la_pkg::mem_req_t cap_req,
    input  la_pkg::mem_req_t regen_req,
    input  la_pkg::sample_t  mem_rdata,
    output la_pkg::mem_req_t mem_req,
    output logic             capture_arm,
    output logic             regen_start,
    output la_pkg::status_t  status,
    output la_pkg::sample_t  read_data
);

    la_pkg::phase_t   phase;
    la_pkg::mem_req_t rd_req;
    logic             acc_arm;
    logic             acc_regen;
    logic             acc_read;
    logic             rd_wait;                   // Display read in flight

    // Single place for command acceptance, arm wins over regen over read
    always_comb begin
        acc_arm   = cmd.arm && (phase == la_pkg::IDLE || phase == la_pkg::CAPTURED
                                || phase == la_pkg::READY);
        acc_regen = cmd.regen && !acc_arm
                    && (phase == la_pkg::CAPTURED || phase == la_pkg::READY);
        acc_read  = cmd.read && !acc_arm && !acc_regen && phase == la_pkg::READY;
    end

    assign capture_arm = acc_arm;
    assign regen_start = acc_regen;

    // ==============================
    // Phase FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (cmd_reset) begin
            phase   <= la_pkg::IDLE;
            rd_wait <= 1'b0;
        end else begin
            rd_wait <= (phase == la_pkg::READ) && !rd_wait;
            case (phase)
                la_pkg::IDLE, la_pkg::CAPTURED, la_pkg::READY: begin
                    if (acc_arm)
                        phase <= la_pkg::CAPTURE;
                    else if (acc_regen)
                        phase <= la_pkg::REGEN;  // Re-zoom from READY too
                    else if (acc_read)
                        phase <= la_pkg::READ;
                end
                la_pkg::CAPTURE: if (captured)   phase <= la_pkg::CAPTURED;
                la_pkg::REGEN:   if (regen_done) phase <= la_pkg::READY;
                la_pkg::READ:    if (rd_wait)    phase <= la_pkg::READY;
                default:         phase <= la_pkg::IDLE;
            endcase
        end
    end

    // One display byte per read command
    always_comb begin
        rd_req      = '0;
        rd_req.en   = !rd_wait;
        rd_req.addr = la_pkg::disp_addr(cfg.channel, cfg.byte_addr);
    end

    always_ff @(posedge clk) begin
        if (phase == la_pkg::READ && rd_wait)
            read_data <= mem_rdata;
    end

    // Memory port owner follows the phase
    always_comb begin
        case (phase)
            la_pkg::CAPTURE: mem_req = cap_req;
            la_pkg::REGEN:   mem_req = regen_req;
            la_pkg::READ:    mem_req = rd_req;
            default:         mem_req = '0;
        endcase
    end

    always_comb begin
        status.busy     = (phase == la_pkg::CAPTURE) || (phase == la_pkg::REGEN)
                          || (phase == la_pkg::READ);
        status.armed    = armed;
        status.captured = captured;
        status.ready    = (phase == la_pkg::READY);
    end

endmodule

// File: design/logic_analyzer_top.sv
`timescale 1ns/100ps

module logic_analyzer_top (
    input  logic             clk,
    input  logic             cmd_reset,
    input  la_pkg::sample_t  probe,
    input  la_pkg::bus_req_t bus,
    output logic [7:0]       rdata,
    output la_pkg::status_t  status               // Status lamps, same as REG_STATUS
);

    la_pkg::cfg_t     cfg;
    la_pkg::cmd_t     cmd;
    la_pkg::sample_t  sample;
    la_pkg::sample_t  mem_rdata;
    la_pkg::sample_t  read_data;
    la_pkg::mem_req_t cap_req;
    la_pkg::mem_req_t regen_req;
    la_pkg::mem_req_t mem_req;
    logic             strobe;
    logic             capture_arm;
    logic             regen_start;
    logic             regen_done;
    logic             armed;
    logic             captured;

    probe_front u_probe_front (
        .clk(clk), .cmd_reset(cmd_reset), .probe(probe), .debug_en(cfg.debug_en),
        .sample(sample), .strobe(strobe)
    );

    capture_engine u_capture_engine (
        .clk(clk), .cmd_reset(cmd_reset), .arm(capture_arm), .sample(sample),
        .strobe(strobe), .trig(cfg.trig), .window(cfg.window), .armed(armed),
        .captured(captured), .mem_req(cap_req)
    );

    regen_engine u_regen_engine (
        .clk(clk), .cmd_reset(cmd_reset), .start(regen_start), .window(cfg.window),
        .mem_req(regen_req), .mem_rdata(mem_rdata), .done(regen_done)
    );

    sample_ram u_sample_ram (
        .clk(clk), .mem_req(mem_req), .rdata(mem_rdata)
    );

    bus_regs u_bus_regs (
        .clk(clk), .cmd_reset(cmd_reset), .bus(bus), .rdata(rdata), .cfg(cfg),
        .cmd(cmd), .status(status), .read_data(read_data)
    );

    phase_ctrl u_phase_ctrl (
        .clk(clk), .cmd_reset(cmd_reset), .cmd(cmd), .cfg(cfg), .captured(captured),
        .armed(armed), .regen_done(regen_done), .cap_req(cap_req), .regen_req(regen_req),
        .mem_rdata(mem_rdata), .mem_req(mem_req), .capture_arm(capture_arm),
        .regen_start(regen_start), .status(status), .read_data(read_data)
    );

endmodule

// File: bench/tb_logic_analyzer.sv
`timescale 1ns/100ps

module tb_logic_analyzer;

    localparam logic [31:0] LCG_SEED = 32'hc9ae8677;
    localparam int CAPTURES   = 4;                           // Full-length captures at most
    localparam int MAX_RAW    = la_pkg::DISP_BITS * 4;       // 1216 samples at window 3
    localparam int WATCHDOG_CYCLES = CAPTURES * MAX_RAW * la_pkg::SAMPLE_DIV + 150000;
    localparam int POLL_LIMIT = 40000;                       // Status polls per wait
    localparam int SEQ_BYTES  = 4;                           // Display bytes rebuilt
    localparam int SEQ_LEN    = SEQ_BYTES * 8;
    localparam la_pkg::status_t READY_MASK    = '{busy: 1'b0, armed: 1'b0,
                                                  captured: 1'b0, ready: 1'b1};
    localparam la_pkg::status_t CAPTURED_MASK = '{busy: 1'b0, armed: 1'b0,
                                                  captured: 1'b1, ready: 1'b0};

    logic             clk;
    logic             cmd_reset;
    la_pkg::sample_t  probe;
    la_pkg::bus_req_t bus;
    logic [7:0]       rdata;
    la_pkg::status_t  status;                                // Lamp port

    logic [31:0]      lcg_state;
    string            test_name;
    int               errors;
    int               checks;
    logic [7:0]       seq [SEQ_LEN];                         // Rebuilt counter values
    logic [7:0]       first_count;

    logic_analyzer_top dut (
        .clk(clk), .cmd_reset(cmd_reset), .probe(probe), .bus(bus),
        .rdata(rdata), .status(status)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                              // 50 MHz
    end

    // Hard stop in case a wait never ends
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d clocks, DUT stopped responding", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    // ==============================
    // Helpers
    // ==============================
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [7:0] reverse_bits(input la_pkg::sample_t s);
        logic [7:0] r;
        for (int i = 0; i < 8; i++)
            r[i] = s[7 - i];
        return r;
    endfunction

    // STATUS register layout, busy in bit 0 up to ready in bit 3
    function automatic la_pkg::status_t unpack_status(input logic [7:0] r);
        la_pkg::status_t s;
        s.busy     = r[0];
        s.armed    = r[1];
        s.captured = r[2];
        s.ready    = r[3];
        return s;
    endfunction

    task automatic bus_write(input logic [3:0] addr, input logic [7:0] data);
        @(negedge clk);
        bus = '{sel: 1'b1, write: 1'b1, addr: addr, wdata: data};
        @(negedge clk);
        bus = '0;
        @(negedge clk);                                      // Command takes effect here
    endtask

    task automatic bus_read(input logic [3:0] addr, output logic [7:0] data);
        @(negedge clk);
        bus = '{sel: 1'b1, write: 1'b0, addr: addr, wdata: 8'h00};
        @(negedge clk);
        bus = '0;
        data = rdata;                                        // Registered at the edge between
    endtask

    task automatic check_byte(input la_pkg::sample_t exp, input la_pkg::sample_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected %h actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_status(input la_pkg::status_t exp, input la_pkg::status_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s expected busy/armed/captured/ready %b actual %b",
                     test_name, exp, act);
        end
    endtask

    // Polls STATUS until every bit of mask is set
    task automatic wait_status(input string what, input la_pkg::status_t mask);
        logic [7:0]      r;
        la_pkg::status_t st;
        int              polls;
        polls = 0;
        st = '0;
        while ((st & mask) != mask && polls < POLL_LIMIT) begin
            bus_read(la_pkg::REG_STATUS, r);
            st = unpack_status(r);
            polls++;
        end
        if ((st & mask) != mask) begin
            errors++;
            $display("%s: gave up waiting for %s after %0d status polls",
                     test_name, what, polls);
        end
    endtask

    task automatic hold_probe(input la_pkg::sample_t val);
        @(negedge clk);
        probe = val;
        repeat (2 * la_pkg::SAMPLE_DIV + 4) @(negedge clk);  // Previous sample settles too
    endtask

    task automatic read_display(input logic [2:0] ch, input logic [5:0] byte_off,
                                output la_pkg::sample_t data);
        bus_write(la_pkg::REG_CHAN, {5'd0, ch});
        bus_write(la_pkg::REG_BYTE, {2'd0, byte_off});
        bus_write(la_pkg::REG_CTRL, 8'h04);
        wait_status("display read", READY_MASK);
        bus_read(la_pkg::REG_DATA, data);
    endtask

    task automatic reg_roundtrip(input logic [3:0] addr, input logic [7:0] val);
        logic [7:0] r;
        bus_write(addr, val);
        bus_read(addr, r);
        check_byte(val, r);
    endtask

    // Rebuilds samples from all eight channels, then undoes the debug bit reversal
    task automatic collect_counts();
        la_pkg::sample_t row [la_pkg::NUM_CH];
        la_pkg::sample_t smp;
        for (int j = 0; j < SEQ_BYTES; j++) begin
            for (int c = 0; c < la_pkg::NUM_CH; c++)
                read_display(3'(c), 6'(j), row[c]);
            for (int i = 0; i < 8; i++) begin
                for (int c = 0; c < la_pkg::NUM_CH; c++)
                    smp[c] = row[c][7 - i];                  // Oldest sample in MSB
                seq[j * 8 + i] = reverse_bits(smp);
            end
        end
    endtask

    task automatic report_test(input int err0);
        $display("%s finished, %0d errors", test_name, errors - err0);
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic reset_and_regs();
        int              err0;
        logic [7:0]      r;
        la_pkg::status_t zero_st;
        test_name = "reset_regs";
        err0 = errors;
        zero_st = '0;
        bus_read(la_pkg::REG_STATUS, r);
        check_status(zero_st, unpack_status(r));
        reg_roundtrip(la_pkg::REG_CHAN, 8'h05);
        reg_roundtrip(la_pkg::REG_BYTE, 8'h25);
        reg_roundtrip(la_pkg::REG_TRIG, 8'h0b);
        reg_roundtrip(la_pkg::REG_WINDOW, 8'h02);
        reg_roundtrip(la_pkg::REG_DEBUG, 8'h01);
        bus_write(la_pkg::REG_CTRL, 8'h02);                  // Regen, ignored in IDLE
        bus_read(la_pkg::REG_STATUS, r);
        check_status(zero_st, unpack_status(r));
        bus_write(la_pkg::REG_CTRL, 8'h04);                  // Read, ignored too
        bus_read(la_pkg::REG_STATUS, r);
        check_status(zero_st, unpack_status(r));
        report_test(err0);
    endtask

    // Constant probe after the edge, so every column matches V
    task automatic edge_capture(input string name, input logic falling, input logic [1:0] win);
        int              err0;
        logic [31:0]     rnd;
        logic [2:0]      t;
        la_pkg::sample_t v;
        la_pkg::sample_t got;
        logic [7:0]      r;
        la_pkg::status_t armed_st;
        test_name = name;
        err0 = errors;
        armed_st = '{busy: 1'b1, armed: 1'b1, captured: 1'b0, ready: 1'b0};
        rnd = next_rand();
        t = rnd[18:16];
        v = rnd[27:20];
        v[t] = !falling;                                     // Edge lands on channel t
        bus_write(la_pkg::REG_DEBUG, 8'h00);
        hold_probe(falling ? 8'hff : 8'h00);
        bus_write(la_pkg::REG_WINDOW, {6'd0, win});
        bus_write(la_pkg::REG_TRIG, {4'd0, falling, t});
        bus_write(la_pkg::REG_CTRL, 8'h01);
        bus_read(la_pkg::REG_STATUS, r);
        check_status(armed_st, unpack_status(r));
        check_status(armed_st, status);                      // Lamps agree
        @(negedge clk);
        probe = v;
        wait_status("capture", CAPTURED_MASK);
        bus_write(la_pkg::REG_CTRL, 8'h02);
        wait_status("regen", READY_MASK);
        for (int c = 0; c < la_pkg::NUM_CH; c++) begin
            for (int j = 0; j < la_pkg::DISP_BYTES; j++) begin
                read_display(3'(c), 6'(j), got);
                check_byte(v[c] ? 8'hff : 8'h00, got);
            end
        end
        report_test(err0);
    endtask

    // Channel 7 is counter bit 0, so the trigger hits an odd count
    task automatic debug_pattern();
        int err0;
        test_name = "debug_w1";
        err0 = errors;
        bus_write(la_pkg::REG_WINDOW, 8'h01);
        bus_write(la_pkg::REG_TRIG, 8'h07);
        bus_write(la_pkg::REG_DEBUG, 8'h01);
        bus_write(la_pkg::REG_CTRL, 8'h01);
        wait_status("capture", CAPTURED_MASK);
        bus_write(la_pkg::REG_CTRL, 8'h02);
        wait_status("regen", READY_MASK);
        collect_counts();
        check_byte(8'h01, seq[0] & 8'h01);                   // Odd start
        for (int k = 1; k < SEQ_LEN; k++)
            check_byte(seq[0] + 8'(2 * k), seq[k]);          // Every second raw sample
        first_count = seq[0];
        report_test(err0);
    endtask

    task automatic rezoom_and_rearm();
        int              err0;
        logic [7:0]      r;
        la_pkg::status_t armed_st;
        test_name = "rezoom_w0";
        err0 = errors;
        armed_st = '{busy: 1'b1, armed: 1'b1, captured: 1'b0, ready: 1'b0};
        bus_write(la_pkg::REG_WINDOW, 8'h00);
        bus_write(la_pkg::REG_CTRL, 8'h02);                  // Same raw data, no arm
        wait_status("regen", READY_MASK);
        collect_counts();
        check_byte(first_count, seq[0]);
        for (int k = 1; k < SEQ_LEN; k++)
            check_byte(first_count + 8'(k), seq[k]);
        // Quiet probes so the new arm stays armed
        bus_write(la_pkg::REG_DEBUG, 8'h00);
        bus_write(la_pkg::REG_TRIG, 8'h00);
        hold_probe(8'h00);
        bus_write(la_pkg::REG_CTRL, 8'h01);
        bus_read(la_pkg::REG_STATUS, r);
        check_status(armed_st, unpack_status(r));
        report_test(err0);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        cmd_reset = 1'b1;
        probe     = '0;
        bus       = '0;
        lcg_state = LCG_SEED;
        errors    = 0;
        checks    = 0;
        repeat (4) @(negedge clk);
        cmd_reset = 1'b0;

        reset_and_regs();
        edge_capture("rising_w0", 1'b0, 2'd0);
        edge_capture("falling_w3", 1'b1, 2'd3);
        debug_pattern();
        rezoom_and_rearm();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: logic_analyzer_top.f
design/la_pkg.sv
design/probe_front.sv
design/capture_engine.sv
design/regen_engine.sv
design/sample_ram.sv
design/bus_regs.sv
design/phase_ctrl.sv
design/logic_analyzer_top.sv
bench/tb_logic_analyzer.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the logic analyzer testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f logic_analyzer_top.f \
    --top-module tb_logic_analyzer -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
